// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

  // first fetch address after reset
  localparam logic [31:0] reset_vector = 32'h8000_0000;

  // instruction memory geometry, in words
  localparam int imem_depth = 32;
  localparam int imem_aw    = 5;

  // image shared with the testbench
  localparam string imem_file = "sim/program.hex";

  // worst case sram read latency in cycles
  localparam int lat_max = 7;

  // one fetch request from the pc generator
  typedef struct packed {
    logic [31:0] pc;
  } fetch_req_t;

  // axi-lite read address beat
  typedef struct packed {
    logic [31:0] araddr;
  } axi_ar_t;

  // axi-lite read data beat, no resp field
  typedef struct packed {
    logic [31:0] rdata;
  } axi_r_t;

  // registered fetch result, pc travels with its word
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } ifu_resp_t;

  // predecoded packet to the next stage
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [2:0]  cls;
    logic [31:0] next_pc;
  } fetch_out_t;

endpackage

// ==== hw/rv_pkg.sv ====
package rv_pkg;

  // rv32i major opcodes, bits 6:0
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_reg    = 7'b011_0011;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;

  // one instruction word, four field layouts
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } stype;
    // branch offset is scattered, bit 0 implied zero
    struct packed {
      logic        imm12;
      logic [5:0]  imm10_5;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [3:0]  imm4_1;
      logic        imm11;
      logic [6:0]  opcode;
    } btype;
    struct packed {
      logic        imm20;
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } jtype;
  } rv_inst_u;

  // coarse class reported with each packet
  typedef enum logic [2:0] {
    cls_alu, cls_load, cls_store, cls_branch,
    cls_jal, cls_jalr, cls_upper, cls_other
  } inst_class_e;

endpackage

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        redir_valid,
  input  logic [31:0] redir_pc,
  output logic        req_valid,
  output fetch_req_t  req,
  input  logic        req_ready
);

  // current fetch pc
  logic [31:0] pc;
  // request handed to the ifu, waiting for its redirect
  logic        busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= reset_vector;
      req_valid <= 1'b0;
      busy      <= 1'b0;
    end else begin
      if (redir_valid) begin
        // next pc known, offer it right away
        pc        <= redir_pc;
        req_valid <= 1'b1;
        busy      <= 1'b0;
      end else if (req_valid && req_ready) begin
        // accepted, stay quiet until predecode answers
        req_valid <= 1'b0;
        busy      <= 1'b1;
      end else if (!busy) begin
        // first request after reset
        req_valid <= 1'b1;
      end
    end
  end

  // request payload is the pc register itself
  assign req.pc = pc;

  // redirect targets from predecode must stay word aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst)
    req_valid |-> (req.pc[1:0] == 2'b00)
  );

endmodule

// ==== hw/ifu.sv ====
`timescale 1ns/1ps

module ifu import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // fetch request from pc_gen
  input  logic       req_valid,
  input  fetch_req_t req,
  output logic       req_ready,
  // axi-lite read address
  output logic       arvalid,
  output axi_ar_t    ar,
  input  logic       arready,
  // axi-lite read data
  input  logic       rvalid,
  input  axi_r_t     r,
  output logic       rready,
  // registered word to predecode
  output logic       resp_valid,
  output ifu_resp_t  resp,
  input  logic       resp_ready
);

  // address beat offered, no arready yet
  logic        wait_for_ar;
  // one request in flight until its r beat
  logic        outstanding;
  // pc of the request in flight
  logic [31:0] pc_q;

  // only one item between pc_gen and the output
  assign req_ready = !outstanding && !resp_valid;
  assign arvalid   = wait_for_ar;
  // accept data whenever the response slot is free
  assign rready    = !resp_valid;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_for_ar <= 1'b0;
      outstanding <= 1'b0;
      resp_valid  <= 1'b0;
    end else begin
      if (req_valid && req_ready) begin
        wait_for_ar <= 1'b1;
        outstanding <= 1'b1;
      end else if (wait_for_ar && arready) begin
        wait_for_ar <= 1'b0;
      end
      if (rvalid && rready) begin
        outstanding <= 1'b0;
        resp_valid  <= 1'b1;
      end else if (resp_valid && resp_ready) begin
        resp_valid  <= 1'b0;
      end
    end
  end

  // payload, captured on the handshakes
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      ar.araddr <= req.pc;
      pc_q      <= req.pc;
    end
    if (rvalid && rready) begin
      resp.pc   <= pc_q;
      resp.inst <= r.rdata;
    end
  end

  // axi rule, address beat held until accepted
  a_ar_hold : assert property (
    @(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(ar.araddr)
  );

  // slave must not answer a read that was never issued
  a_r_expected : assert property (
    @(posedge clk) disable iff (rst)
    rvalid && rready |-> outstanding && !wait_for_ar
  );

endmodule

// ==== hw/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram import fetch_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    arvalid,
  input  axi_ar_t ar,
  output logic    arready,
  output logic    rvalid,
  output axi_r_t  r,
  input  logic    rready
);

  // counter wide enough for lat_max
  typedef logic [$clog2(lat_max + 1) - 1:0] lat_t;

  logic [31:0]        mem [imem_depth];
  logic [31:0]        offset;
  logic [imem_aw-1:0] idx_q;
  logic [15:0]        lfsr;
  lat_t               delay;
  lat_t               lat_pick;
  // address taken, latency still running
  logic               pending;
  logic               ar_take;

  initial $readmemh(imem_file, mem);

  // word index relative to the reset vector, wraps at depth
  assign offset = ar.araddr - reset_vector;

  // latency 1 to lat_max from the lfsr
  assign lat_pick = lat_t'(lfsr % lat_max) + lat_t'(1);

  // one request at a time, pulse arready for a cycle
  assign ar_take = arvalid && !arready && !pending && !rvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr    <= 16'hace1;
      arready <= 1'b0;
      pending <= 1'b0;
      rvalid  <= 1'b0;
      delay   <= '0;
    end else begin
      // taps 16 14 13 11, free running
      lfsr    <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      arready <= ar_take;
      if (arvalid && arready) begin
        pending <= 1'b1;
        delay   <= lat_pick;
      end else if (pending) begin
        if (delay == lat_t'(1)) begin
          pending <= 1'b0;
          rvalid  <= 1'b1;
        end else begin
          delay <= delay - lat_t'(1);
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      idx_q <= offset[imem_aw+1:2];
    end
    if (pending && delay == lat_t'(1)) begin
      r.rdata <= mem[idx_q];
    end
  end

  // r beat held while the master stalls
  a_r_hold : assert property (
    @(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(r.rdata)
  );

endmodule

// ==== hw/predecode.sv ====
`timescale 1ns/1ps

module predecode import fetch_pkg::*, rv_pkg::*; (
  input  logic        resp_valid,
  input  ifu_resp_t   resp,
  output logic        resp_ready,
  output logic        out_valid,
  output fetch_out_t  out,
  input  logic        out_ready,
  output logic        redir_valid,
  output logic [31:0] redir_pc
);

  rv_inst_u    inst;
  inst_class_e cls;
  logic [31:0] imm_j;
  logic [31:0] imm_b;
  logic [31:0] next_pc;

  assign inst = resp.inst;

  // opcode sits in the same bits for every view
  always_comb begin
    case (inst.itype.opcode)
      op_imm, op_reg:  cls = cls_alu;
      op_load:         cls = cls_load;
      op_store:        cls = cls_store;
      op_branch:       cls = cls_branch;
      op_jal:          cls = cls_jal;
      op_jalr:         cls = cls_jalr;
      op_lui, op_auipc: cls = cls_upper;
      default:         cls = cls_other;
    endcase
  end

  // sign extended jal offset
  assign imm_j = {{11{inst.jtype.imm20}}, inst.jtype.imm20, inst.jtype.imm19_12,
                  inst.jtype.imm11, inst.jtype.imm10_1, 1'b0};
  // sign extended branch offset
  assign imm_b = {{19{inst.btype.imm12}}, inst.btype.imm12, inst.btype.imm11,
                  inst.btype.imm10_5, inst.btype.imm4_1, 1'b0};

  // static prediction, backward branches taken
  always_comb begin
    if (cls == cls_jal) begin
      next_pc = resp.pc + imm_j;
    end else if (cls == cls_branch && imm_b[31]) begin
      next_pc = resp.pc + imm_b;
    end else begin
      next_pc = resp.pc + 32'd4;
    end
  end

  assign out.pc      = resp.pc;
  assign out.inst    = resp.inst;
  assign out.cls     = cls;
  assign out.next_pc = next_pc;

  // pass-through handshake, redirect on the output transfer
  assign out_valid   = resp_valid;
  assign resp_ready  = out_ready;
  assign redir_valid = resp_valid && out_ready;
  assign redir_pc    = next_pc;

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  output logic       out_valid,
  output fetch_out_t out,
  input  logic       out_ready
);

  // pc_gen to ifu
  logic        req_valid;
  logic        req_ready;
  fetch_req_t  req;
  // ifu to sram
  logic        arvalid;
  logic        arready;
  axi_ar_t     ar;
  logic        rvalid;
  logic        rready;
  axi_r_t      r;
  // ifu to predecode
  logic        resp_valid;
  logic        resp_ready;
  ifu_resp_t   resp;
  // predecode back to pc_gen
  logic        redir_valid;
  logic [31:0] redir_pc;

  pc_gen u_pc_gen (
    .clk, .rst, .redir_valid, .redir_pc, .req_valid, .req, .req_ready
  );

  ifu u_ifu (
    .clk, .rst,
    .req_valid, .req, .req_ready,
    .arvalid, .ar, .arready,
    .rvalid, .r, .rready,
    .resp_valid, .resp, .resp_ready
  );

  axi_sram u_axi_sram (
    .clk, .rst, .arvalid, .ar, .arready, .rvalid, .r, .rready
  );

  predecode u_predecode (
    .resp_valid, .resp, .resp_ready,
    .out_valid, .out, .out_ready,
    .redir_valid, .redir_pc
  );

endmodule

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*, rv_pkg::*; ();

  // run length and stimulus seed
  localparam int          num_pkts     = 200;
  localparam int          clk_period   = 100;
  localparam int          reset_cycles = 10;
  localparam logic [31:0] rand_seed    = 32'h3266;
  // worst case per packet plus the reset phase
  localparam int          timeout_ns   =
    (num_pkts * (lat_max + 8) + reset_cycles) * clk_period;

  logic       clk;
  logic       rst;
  logic       out_valid;
  fetch_out_t out;
  logic       out_ready;

  // copy of the instruction image for the reference
  logic [31:0] img [imem_depth];

  logic [31:0] rand_state;
  logic [31:0] exp_pc;
  fetch_out_t  exp;
  fetch_out_t  held;
  logic        stalled;
  int          errors;
  int          pkts;
  // class coverage over the stream
  int          n_jal;
  int          n_bwd;
  int          n_fwd;

  fetch_top UUT (
    .clk,
    .rst,
    .out_valid,
    .out,
    .out_ready
  );

  initial $readmemh(imem_file, img);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // expected packet for one pc, straight from the isa encoding
  function automatic fetch_out_t expected_packet(input logic [31:0] pc);
    logic [31:0] offset;
    logic [31:0] word;
    logic [31:0] off_j;
    logic [31:0] off_b;
    inst_class_e cls;
    fetch_out_t  pkt;
    offset = pc - reset_vector;
    // word index wraps at the image depth
    word   = img[offset[imem_aw+1:2]];
    case (word[6:0])
      op_imm, op_reg:   cls = cls_alu;
      op_load:          cls = cls_load;
      op_store:         cls = cls_store;
      op_branch:        cls = cls_branch;
      op_jal:           cls = cls_jal;
      op_jalr:          cls = cls_jalr;
      op_lui, op_auipc: cls = cls_upper;
      default:          cls = cls_other;
    endcase
    // j immediate: 20 | 10:1 | 11 | 19:12
    off_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    // b immediate: 12 | 10:5 | 4:1 | 11
    off_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    pkt.pc   = pc;
    pkt.inst = word;
    pkt.cls  = cls;
    if (cls == cls_jal) begin
      pkt.next_pc = pc + off_j;
    end else if (cls == cls_branch && off_b[31]) begin
      // backward branch predicted taken
      pkt.next_pc = pc + off_b;
    end else begin
      pkt.next_pc = pc + 32'd4;
    end
    return pkt;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("Error: %s got %h expected %h at %0t", name, got, want, $time);
      errors++;
    end
  endtask

  // sampled on the falling edge, inputs and outputs settled
  always @(negedge clk) begin
    if (rst) begin
      compare_value("out_valid", {31'b0, out_valid}, 32'd0);
    end else begin
      // packet stalled last cycle must still be there, unchanged
      if (stalled) begin
        compare_value("out_valid", {31'b0, out_valid}, 32'd1);
        compare_value("out.pc", out.pc, held.pc);
        compare_value("out.inst", out.inst, held.inst);
        compare_value("out.cls", {29'b0, out.cls}, {29'b0, held.cls});
        compare_value("out.next_pc", out.next_pc, held.next_pc);
      end
      // transfer happens on the coming rising edge
      if (out_valid && out_ready && pkts < num_pkts) begin
        exp = expected_packet(exp_pc);
        compare_value("out.pc", out.pc, exp.pc);
        compare_value("out.inst", out.inst, exp.inst);
        compare_value("out.cls", {29'b0, out.cls}, {29'b0, exp.cls});
        compare_value("out.next_pc", out.next_pc, exp.next_pc);
        if (exp.cls == cls_jal) begin
          n_jal++;
        end else if (exp.cls == cls_branch) begin
          if (exp.next_pc != exp.pc + 32'd4) begin
            n_bwd++;
          end else begin
            n_fwd++;
          end
        end
        // chain follows the reference, not the dut
        exp_pc = exp.next_pc;
        pkts++;
      end
      stalled = out_valid && !out_ready;
      held    = out;
    end
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("fetch stream stalled, only %0d of %0d packets seen", pkts, num_pkts);
    $display("%0d packets checked, %0d errors", pkts, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    out_ready  = 1'b0;
    rand_state = rand_seed;
    exp_pc     = reset_vector;
    stalled    = 1'b0;
    errors     = 0;
    pkts       = 0;
    n_jal      = 0;
    n_bwd      = 0;
    n_fwd      = 0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    // one lfsr step per ready bit
    while (pkts < num_pkts) begin
      @(posedge clk);
      #1;
      rand_state = lfsr_next(rand_state);
      out_ready  = rand_state[0];
    end
    @(posedge clk);
    #1;
    out_ready = 1'b0;
    // image must have driven every prediction path
    if (n_jal == 0) begin
      $display("no jal packet went through the fetch stream");
      errors++;
    end
    if (n_bwd == 0) begin
      $display("no backward branch went through the fetch stream");
      errors++;
    end
    if (n_fwd == 0) begin
      $display("no forward branch went through the fetch stream");
      errors++;
    end
    $display("%0d packets checked, %0d jal, %0d backward, %0d forward, %0d errors",
             pkts, n_jal, n_bwd, n_fwd, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/program.hex ====
// one rv32i word per line, index 0 at 8000_0000h, comment gives index and instruction
00100093 // 0  addi x1, x0, 1
00200113 // 1  addi x2, x0, 2
002081B3 // 2  add x3, x1, x2
00000863 // 3  beq x0, x0, +16 forward, not taken
0000A203 // 4  lw x4, 0(x1)
0040A223 // 5  sw x4, 4(x1)
123452B7 // 6  lui x5, 0x12345
00001317 // 7  auipc x6, 0x1
00008067 // 8  jalr x0, 0(x1), falls through
0FF0000F // 9  fence, class other
00209463 // 10 bne x1, x2, +8 forward, not taken
00000013 // 11 nop
00000073 // 12 ecall, class other
00000013 // 13 nop
01C0006F // 14 jal x0, +28 to index 21
00000013 // 15 nop, skipped
00308193 // 16 addi x3, x1, 3
0000A283 // 17 lw x5, 0(x1)
40208233 // 18 sub x4, x1, x2
0050A423 // 19 sw x5, 8(x1)
018000EF // 20 jal x1, +24 to index 26
00000013 // 21 nop
FE0094E3 // 22 bne x1, x0, -24 backward to index 16
00000013 // 23 nop, skipped
00000013 // 24 nop, skipped
00000013 // 25 nop, skipped
000013B7 // 26 lui x7, 0x1
00110113 // 27 addi x2, x2, 1
0020C463 // 28 blt x1, x2, +8 forward, not taken
00000013 // 29 nop
00000033 // 30 add x0, x0, x0
00000013 // 31 nop, next pc wraps to index 0

// ==== src.f ====
hw/fetch_pkg.sv
hw/rv_pkg.sv
hw/pc_gen.sv
hw/ifu.sv
hw/axi_sram.sv
hw/predecode.sv
hw/fetch_top.sv
sim/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: rv_fetch_front

sources:
  # packages first, both used by rtl and testbench
  - hw/fetch_pkg.sv
  - hw/rv_pkg.sv
  # rtl, leaves before the top level
  - hw/pc_gen.sv
  - hw/ifu.sv
  - hw/axi_sram.sv
  - hw/predecode.sv
  - hw/fetch_top.sv
  # testbench, top module fetch_tb
  - target: simulation
    files:
      - sim/fetch_tb.sv
